/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module systolic_dot_tb \
  -f systolic_dot.f -o systolic_dot_sim > build.log 2>&1 &&
  ./obj_dir/systolic_dot_sim > sim.log 2>&1 ||
  echo "Something failed" >> sim.log
cat sim.log
if grep -q "Something failed" sim.log; then
  exit 1
fi
exit 0

/* systolic_dot.f */
verilog/systolic_dot_pkg.sv
verilog/operand_buffer.sv
verilog/lpe_control_unit.sv
verilog/lpe_mac_datapath.sv
verilog/linear_processing_element.sv
verilog/systolic_dot_top.sv
testbench/systolic_dot_chk.sv
testbench/systolic_dot_tb.sv

/* testbench/systolic_dot_chk.sv */
`default_nettype none

module systolic_dot_chk (
  input wire                                      clk,
  input wire                                      rst,
  input wire                                      result_valid,
  input wire                                      result_ready,
  input wire [systolic_dot_pkg::STREAM_WIDTH-1:0] result_data,
  input wire                                      result_last,
  input wire [systolic_dot_pkg::USER_WIDTH-1:0]   result_user,
  input wire [systolic_dot_pkg::PE_NUMBER-1:0]    err_unaligned,
  input wire [systolic_dot_pkg::PE_NUMBER-1:0]    err_user_flag
);

  localparam logic [systolic_dot_pkg::USER_WIDTH-1:0] RSLT_FLAG =
    systolic_dot_pkg::USER_WIDTH'(1) << systolic_dot_pkg::USER_RSLT_BIT;

  // Number of failed assertions
  int fail_count = 0;

  // Error bits are single-cycle pulses
  unaligned_pulse: assert property (@(posedge clk) disable iff (rst)
    (err_unaligned & $past(err_unaligned)) == '0)
    else begin
      fail_count++;
      $error("err_unaligned high for two cycles in a row");
    end

  user_flag_pulse: assert property (@(posedge clk) disable iff (rst)
    (err_user_flag & $past(err_user_flag)) == '0)
    else begin
      fail_count++;
      $error("err_user_flag high for two cycles in a row");
    end

  // Stalled output holds its beat
  stall_hold: assert property (@(posedge clk) disable iff (rst)
    result_valid && !result_ready |=> result_valid && $stable(result_data))
    else begin
      fail_count++;
      $error("result beat changed while result_ready was low");
    end

  result_beat: assert property (@(posedge clk) disable iff (rst)
    result_valid |-> result_last && result_user == RSLT_FLAG)
    else begin
      fail_count++;
      $error("result beat without result flag or last");
    end

  // Covers the reset window and the first cycle after it
  reset_quiet: assert property (@(posedge clk)
    $past(rst) |-> !result_valid && err_unaligned == '0 && err_user_flag == '0)
    else begin
      fail_count++;
      $error("output active during or right after reset");
    end

endmodule

bind systolic_dot_top systolic_dot_chk chk0 (
  .clk(clk), .rst(rst),
  .result_valid(result_valid), .result_ready(result_ready),
  .result_data(result_data), .result_last(result_last), .result_user(result_user),
  .err_unaligned(err_unaligned), .err_user_flag(err_user_flag)
);

`default_nettype wire

/* testbench/systolic_dot_tb.sv */
`default_nettype none

module systolic_dot_tb;

  localparam int NPE = systolic_dot_pkg::PE_NUMBER;
  localparam int DW = systolic_dot_pkg::DATA_WIDTH;
  localparam int AW = systolic_dot_pkg::ACC_WIDTH;
  localparam int UW = systolic_dot_pkg::USER_WIDTH;
  localparam int MAX_LEN = 8;
  localparam int LIMIT = 2000;
  localparam logic [UW-1:0] OP_FLAG = UW'(1) << systolic_dot_pkg::USER_OP_BIT;
  localparam logic [UW-1:0] BOTH_FLAGS = OP_FLAG | (UW'(1) << systolic_dot_pkg::USER_RSLT_BIT);

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic [NPE-1:0] a_valid;
  logic [NPE-1:0][DW-1:0] a_data;
  logic [NPE-1:0] a_last;
  wire [NPE-1:0] a_ready;
  logic b_valid;
  logic [DW-1:0] b_data;
  logic b_last;
  logic [UW-1:0] b_user;
  wire b_ready;
  wire result_valid;
  wire [systolic_dot_pkg::STREAM_WIDTH-1:0] result_data;
  wire result_last;
  wire [UW-1:0] result_user;
  logic result_ready;
  wire [NPE-1:0] err_unaligned;
  wire [NPE-1:0] err_user_flag;

  integer seed = 32'h53402fd4;
  int mismatches = 0;
  int timeouts = 0;
  int failures = 0;
  bit stall_on = 1'b0;
  bit err_expected = 1'b0;

  logic [DW-1:0] vec_a [NPE][MAX_LEN];
  logic [DW-1:0] vec_b [MAX_LEN];
  int vec_len;

  always #2 clk = !clk;

  systolic_dot_top dut0 (
    .clk(clk), .rst(rst),
    .a_valid(a_valid), .a_data(a_data), .a_last(a_last), .a_ready(a_ready),
    .b_valid(b_valid), .b_data(b_data), .b_last(b_last), .b_user(b_user), .b_ready(b_ready),
    .result_valid(result_valid), .result_data(result_data), .result_last(result_last),
    .result_user(result_user), .result_ready(result_ready),
    .err_unaligned(err_unaligned), .err_user_flag(err_user_flag)
  );

  // Error pulses outside the error tests
  always @(posedge clk) begin
    if (!rst && !err_expected && ((|err_unaligned) || (|err_user_flag))) begin
      $display("unexpected error pulse: unaligned %h user flag %h", err_unaligned,
               err_user_flag);
      failures++;
    end
  end

  function automatic logic pick_ready();
    integer r;
    r = $random(seed);
    return stall_on ? r[0] : 1'b1;
  endfunction

  function automatic logic [AW-1:0] dot_product(input int k);
    logic [AW-1:0] sum;
    sum = '0;
    for (int i = 0; i < vec_len; i++) begin
      sum = sum + AW'(vec_a[k][i]) * AW'(vec_b[i]);
    end
    return sum;
  endfunction

  task automatic make_vectors(input int n);
    vec_len = n;
    for (int i = 0; i < n; i++) begin
      vec_b[i] = DW'($random(seed));
      for (int k = 0; k < NPE; k++) begin
        vec_a[k][i] = DW'($random(seed));
      end
    end
  endtask

  task automatic send_a(input int k, input int n);
    int wait_cnt;
    for (int i = 0; i < n; i++) begin
      a_valid[k] = 1'b1;
      a_data[k] = vec_a[k][i];
      a_last[k] = (i == n - 1);
      wait_cnt = 0;
      while (!a_ready[k] && wait_cnt < LIMIT) begin
        @(negedge clk);
        wait_cnt++;
      end
      if (wait_cnt == LIMIT) begin
        $display("timeout: PE %0d never accepted A beat %0d", k, i);
        timeouts++;
        a_valid[k] = 1'b0;
        return;
      end
      @(negedge clk);
    end
    a_valid[k] = 1'b0;
  endtask

  // A cleared last_ok leaves the closing beat unmarked
  task automatic send_b(input int n, input logic [UW-1:0] user, input bit last_ok);
    int wait_cnt;
    for (int i = 0; i < n; i++) begin
      b_valid = 1'b1;
      b_data = vec_b[i];
      b_last = last_ok && (i == n - 1);
      b_user = user;
      wait_cnt = 0;
      while (!b_ready && wait_cnt < LIMIT) begin
        @(negedge clk);
        wait_cnt++;
      end
      if (wait_cnt == LIMIT) begin
        $display("timeout: column never accepted B beat %0d", i);
        timeouts++;
        b_valid = 1'b0;
        return;
      end
      @(negedge clk);
    end
    b_valid = 1'b0;
  endtask

  task automatic collect_results();
    logic [AW-1:0] expected;
    int wait_cnt;
    for (int k = 0; k < NPE; k++) begin
      expected = dot_product(k);
      wait_cnt = 0;
      result_ready = pick_ready();
      while (!(result_valid && result_ready) && wait_cnt < LIMIT) begin
        @(negedge clk);
        result_ready = pick_ready();
        wait_cnt++;
      end
      if (wait_cnt == LIMIT) begin
        $display("timeout: result of PE %0d never arrived", k);
        timeouts++;
        result_ready = 1'b1;
        return;
      end
      if (result_data !== expected) begin
        $display("mismatch: result_data of PE %0d expected %h got %h", k, expected,
                 result_data);
        mismatches++;
      end
      @(negedge clk);
    end
    result_ready = 1'b1;
  endtask

  task automatic run_set(input int n);
    if (timeouts != 0) begin
      return;
    end
    make_vectors(n);
    fork
      send_a(0, n);
      send_a(1, n);
      send_a(2, n);
      send_a(3, n);
      send_b(n, OP_FLAG, 1'b1);
      collect_results();
    join
  endtask

  task automatic wait_err(input bit user_kind, input int k);
    int wait_cnt;
    logic seen;
    wait_cnt = 0;
    seen = 1'b0;
    while (!seen && wait_cnt < LIMIT) begin
      @(negedge clk);
      seen = user_kind ? err_user_flag[k] : err_unaligned[k];
      wait_cnt++;
    end
    if (!seen) begin
      $display("timeout: PE %0d never raised its error flag", k);
      timeouts++;
    end
    // ERR lasts one cycle, then START
    repeat (3) @(negedge clk);
  endtask

  function automatic int random_len();
    integer r;
    r = $random(seed);
    return 1 + int'($unsigned(r) % MAX_LEN);
  endfunction

  initial begin
    a_valid = '0;
    a_data = '0;
    a_last = '0;
    b_valid = 1'b0;
    b_data = '0;
    b_last = 1'b0;
    b_user = '0;
    result_ready = 1'b1;
    rst = 1'b1;
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    for (int t = 0; t < 6; t++) begin
      run_set(random_len());
    end
    // Random back-pressure on the bottom
    stall_on = 1'b1;
    for (int t = 0; t < 6; t++) begin
      run_set(random_len());
    end
    stall_on = 1'b0;
    run_set(1);
    run_set(1);

    // A on PE 0 ends while B still has a beat to come
    err_expected = 1'b1;
    make_vectors(2);
    fork
      send_a(0, 1);
      send_b(1, OP_FLAG, 1'b0);
      wait_err(1'b0, 0);
    join
    err_expected = 1'b0;
    run_set(random_len());

    // B beat marked as operand and result at once
    err_expected = 1'b1;
    make_vectors(1);
    fork
      send_b(1, BOTH_FLAGS, 1'b1);
      wait_err(1'b1, 0);
    join
    err_expected = 1'b0;
    run_set(random_len());

    $display("errors: %0d mismatches, %0d timeouts, %0d other, %0d assertions", mismatches,
             timeouts, failures, dut0.chk0.fail_count);
    if (mismatches + timeouts + failures + dut0.chk0.fail_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/linear_processing_element.sv */
`default_nettype none

module linear_processing_element #(
  parameter int position = 0
) (
  input  wire                                      clk,
  input  wire                                      rst,
  input  wire                                      up_valid,
  input  wire [systolic_dot_pkg::STREAM_WIDTH-1:0] up_data,
  input  wire                                      up_last,
  input  wire [systolic_dot_pkg::USER_WIDTH-1:0]   up_user,
  output wire                                      up_ready,
  input  wire                                      left_valid,
  input  wire [systolic_dot_pkg::DATA_WIDTH-1:0]   left_data,
  input  wire                                      left_last,
  output wire                                      left_ready,
  output wire                                      down_valid,
  output wire [systolic_dot_pkg::STREAM_WIDTH-1:0] down_data,
  output wire                                      down_last,
  output wire [systolic_dot_pkg::USER_WIDTH-1:0]   down_user,
  input  wire                                      down_ready,
  output wire                                      err_unaligned,
  output wire                                      err_user_flag
);

  // Buffer heads
  wire l_valid;
  wire l_last;
  wire [systolic_dot_pkg::DATA_WIDTH-1:0] l_data;
  wire u_valid;
  wire u_last;
  wire [systolic_dot_pkg::STREAM_WIDTH-1:0] u_data;
  wire [systolic_dot_pkg::USER_WIDTH-1:0] u_user;

  wire store_l;
  wire store_u;
  wire forward_u;
  wire drop_l;
  wire drop_u;
  wire export_rslt;
  wire op_start;
  wire bypass_adder;

  // Both heads advance together on a consumed pair
  wire pair_take = !bypass_adder;
  wire up_fwd = forward_u && down_ready;

  assign down_valid = forward_u || export_rslt;

  operand_buffer #(.width(systolic_dot_pkg::DATA_WIDTH)) u_left_buf (
    .clk(clk), .rst(rst),
    .in_valid(left_valid), .in_data(left_data), .in_last(left_last), .in_user('0),
    .store(store_l), .forward(1'b0), .drop(drop_l), .out_ready(pair_take),
    .in_ready(left_ready), .out_valid(l_valid), .out_data(l_data), .out_last(l_last),
    .out_user()
  );

  operand_buffer #(.width(systolic_dot_pkg::STREAM_WIDTH)) u_up_buf (
    .clk(clk), .rst(rst),
    .in_valid(up_valid), .in_data(up_data), .in_last(up_last), .in_user(up_user),
    .store(store_u), .forward(up_fwd), .drop(drop_u), .out_ready(pair_take),
    .in_ready(up_ready), .out_valid(u_valid), .out_data(u_data), .out_last(u_last),
    .out_user(u_user)
  );

  lpe_control_unit #(.position(position)) u_ctrl (
    .clk(clk), .rst(rst),
    .up_valid(u_valid), .up_ready(pair_take || up_fwd), .up_last(u_last), .up_user(u_user),
    .left_valid(l_valid), .left_ready(pair_take), .left_last(l_last),
    .down_valid(down_valid), .down_ready(down_ready),
    .store_l(store_l), .store_u(store_u), .forward_u(forward_u),
    .drop_l(drop_l), .drop_u(drop_u), .export_rslt(export_rslt),
    .op_start(op_start), .bypass_adder(bypass_adder),
    .err_unaligned(err_unaligned), .err_user_flag(err_user_flag)
  );

  lpe_mac_datapath u_mac (
    .clk(clk), .rst(rst),
    .left_data(l_data), .up_data(u_data), .up_last(u_last), .up_user(u_user),
    .op_start(op_start), .bypass_adder(bypass_adder),
    .export_rslt(export_rslt), .forward_u(forward_u),
    .down_data(down_data), .down_last(down_last), .down_user(down_user)
  );

endmodule

`default_nettype wire

/* verilog/lpe_control_unit.sv */
`default_nettype none

module lpe_control_unit #(
  parameter int position = 0
) (
  input  wire                                    clk,
  input  wire                                    rst,
  input  wire                                    up_valid,
  input  wire                                    up_ready,
  input  wire                                    up_last,
  input  wire [systolic_dot_pkg::USER_WIDTH-1:0] up_user,
  input  wire                                    left_valid,
  input  wire                                    left_ready,
  input  wire                                    left_last,
  input  wire                                    down_valid,
  input  wire                                    down_ready,
  output logic                                   store_l,
  output logic                                   store_u,
  output logic                                   forward_u,
  output logic                                   drop_l,
  output logic                                   drop_u,
  output logic                                   export_rslt,
  output logic                                   op_start,
  output logic                                   bypass_adder,
  output logic                                   err_unaligned,
  output logic                                   err_user_flag
);

  logic [systolic_dot_pkg::ST_WIDTH-1:0] state;
  logic [systolic_dot_pkg::ST_WIDTH-1:0] state_next;
  // Results from above still to pass before our own
  logic [systolic_dot_pkg::PE_INDEX_WIDTH-1:0] timer;
  logic pair_en;
  logic drop_u_reg;

  wire up_op = up_user[systolic_dot_pkg::USER_OP_BIT];
  wire up_rslt = up_user[systolic_dot_pkg::USER_RSLT_BIT];
  wire op_head = up_valid && up_op && !up_rslt;
  wire rslt_head = up_valid && up_rslt && !up_op;
  wire pair = left_valid && op_head;

  // Error sources, only looked at while pairing operands
  wire user_bad = pair_en && up_valid && up_op && up_rslt;
  wire last_bad = pair_en && pair && (left_last != up_last);
  wire pair_ok = pair_en && pair && !last_bad;

  // Bottom PE keeps its B operands, nothing below needs them
  wire fwd_ops = (position != systolic_dot_pkg::PE_NUMBER - 1);

  wire in_end = (state == systolic_dot_pkg::ST_END);
  wire pair_taken = left_valid && left_ready && up_valid && up_ready;
  wire down_taken = down_valid && down_ready;

  assign export_rslt = in_end && (timer == '0);
  assign forward_u = !export_rslt && ((pair_ok && fwd_ops) ||
                     (rslt_head && state != systolic_dot_pkg::ST_ERR));
  // Pair fires only if the forwarded B beat can leave in the same cycle
  assign bypass_adder = !(pair_ok && (down_ready || !fwd_ops));
  // Stale operands from above are discarded while waiting to export
  assign drop_u = drop_u_reg || (in_end && up_valid && up_op);

  always_comb begin
    state_next = state;
    case (state)
      systolic_dot_pkg::ST_START, systolic_dot_pkg::ST_STRL,
      systolic_dot_pkg::ST_STRU, systolic_dot_pkg::ST_MAC: begin
        if (user_bad || last_bad) begin
          state_next = systolic_dot_pkg::ST_ERR;
        end else if (pair_taken) begin
          state_next = (left_last && up_last) ? systolic_dot_pkg::ST_END
                                              : systolic_dot_pkg::ST_MAC;
        end else if (pair) begin
          // Stalled below, hold
          state_next = state;
        end else if (left_valid) begin
          state_next = systolic_dot_pkg::ST_STRL;
        end else if (op_head) begin
          state_next = systolic_dot_pkg::ST_STRU;
        end
      end
      systolic_dot_pkg::ST_END: begin
        if (export_rslt && down_taken) begin
          state_next = systolic_dot_pkg::ST_START;
        end
      end
      systolic_dot_pkg::ST_ERR: begin
        state_next = systolic_dot_pkg::ST_START;
      end
      default: begin
        state_next = systolic_dot_pkg::ST_START;
      end
    endcase
  end

  // Control outputs follow the decided state one cycle later
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= systolic_dot_pkg::ST_START;
      store_l <= 1'b0;
      store_u <= 1'b0;
      drop_l <= 1'b1;
      drop_u_reg <= 1'b1;
      pair_en <= 1'b0;
      op_start <= 1'b1;
      err_unaligned <= 1'b0;
      err_user_flag <= 1'b0;
    end else begin
      state <= state_next;
      store_l <= 1'b1;
      store_u <= 1'b1;
      drop_l <= 1'b0;
      drop_u_reg <= 1'b0;
      pair_en <= 1'b1;
      err_unaligned <= 1'b0;
      err_user_flag <= 1'b0;
      case (state_next)
        // One operand waiting, hold that side
        systolic_dot_pkg::ST_STRL: store_l <= 1'b0;
        systolic_dot_pkg::ST_STRU: store_u <= 1'b0;
        systolic_dot_pkg::ST_END: begin
          store_l <= 1'b0;
          pair_en <= 1'b0;
        end
        systolic_dot_pkg::ST_ERR: begin
          drop_l <= 1'b1;
          drop_u_reg <= 1'b1;
          pair_en <= 1'b0;
          err_unaligned <= last_bad;
          err_user_flag <= user_bad;
        end
        default: begin
        end
      endcase
      // First pair of a vector loads rather than adds
      if (state_next == systolic_dot_pkg::ST_START) begin
        op_start <= 1'b1;
      end else if (pair_taken) begin
        op_start <= 1'b0;
      end
    end
  end

  // Count down results from the PEs above, reload after our own export
  always_ff @(posedge clk) begin
    if (rst || (export_rslt && down_taken)) begin
      timer <= systolic_dot_pkg::PE_INDEX_WIDTH'(position);
    end else if (rslt_head && down_taken && timer != '0) begin
      timer <= timer - 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/lpe_mac_datapath.sv */
`default_nettype none

module lpe_mac_datapath (
  input  wire                                      clk,
  input  wire                                      rst,
  input  wire [systolic_dot_pkg::DATA_WIDTH-1:0]   left_data,
  input  wire [systolic_dot_pkg::STREAM_WIDTH-1:0] up_data,
  input  wire                                      up_last,
  input  wire [systolic_dot_pkg::USER_WIDTH-1:0]   up_user,
  input  wire                                      op_start,
  input  wire                                      bypass_adder,
  input  wire                                      export_rslt,
  input  wire                                      forward_u,
  output logic [systolic_dot_pkg::STREAM_WIDTH-1:0] down_data,
  output logic                                     down_last,
  output logic [systolic_dot_pkg::USER_WIDTH-1:0]  down_user
);

  logic [2*systolic_dot_pkg::DATA_WIDTH-1:0] product;
  logic [systolic_dot_pkg::ACC_WIDTH-1:0] acc;

  // B operand sits in the low bits of the up word
  assign product = left_data * up_data[systolic_dot_pkg::DATA_WIDTH-1:0];

  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
    end else if (!bypass_adder) begin
      if (op_start) begin
        acc <= systolic_dot_pkg::ACC_WIDTH'(product);
      end else begin
        acc <= acc + systolic_dot_pkg::ACC_WIDTH'(product);
      end
    end
  end

  // Down word: own result or the beat passed from above
  always_comb begin
    down_data = '0;
    down_last = 1'b0;
    down_user = '0;
    if (export_rslt) begin
      down_data = acc;
      down_last = 1'b1;
      down_user[systolic_dot_pkg::USER_RSLT_BIT] = 1'b1;
    end else if (forward_u) begin
      down_data = up_data;
      down_last = up_last;
      down_user = up_user;
    end
  end

endmodule

`default_nettype wire

/* verilog/operand_buffer.sv */
`default_nettype none

module operand_buffer #(
  parameter int width = 16
) (
  input  wire                                    clk,
  input  wire                                    rst,
  input  wire                                    in_valid,
  input  wire [width-1:0]                        in_data,
  input  wire                                    in_last,
  input  wire [systolic_dot_pkg::USER_WIDTH-1:0] in_user,
  input  wire                                    store,
  input  wire                                    forward,
  input  wire                                    drop,
  input  wire                                    out_ready,
  output wire                                    in_ready,
  output wire                                    out_valid,
  output wire [width-1:0]                        out_data,
  output wire                                    out_last,
  output wire [systolic_dot_pkg::USER_WIDTH-1:0] out_user
);

  // Entry layout is {last, user, data}
  logic [width+systolic_dot_pkg::USER_WIDTH:0] mem [2];
  logic [1:0] count;
  logic rd_ptr;
  logic wr_ptr;

  wire push = in_valid && in_ready;
  // Head leaves when paired by the datapath or sent down
  wire pop = out_valid && (out_ready || forward);

  assign in_ready = store && (count != 2'd2);
  assign out_valid = (count != 2'd0);
  assign {out_last, out_user, out_data} = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (rst || drop) begin
      count <= 2'd0;
      rd_ptr <= 1'b0;
      wr_ptr <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= !wr_ptr;
      end
      if (pop) begin
        rd_ptr <= !rd_ptr;
      end
      count <= count + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= {in_last, in_user, in_data};
    end
  end

endmodule

`default_nettype wire

/* verilog/systolic_dot_pkg.sv */
`default_nettype none

package systolic_dot_pkg;

  // Operand and accumulator widths
  localparam int DATA_WIDTH = 16;
  localparam int ACC_WIDTH = 40;

  // Down stream carries either a zero-extended operand or a full result
  localparam int STREAM_WIDTH = ACC_WIDTH;

  // Column size
  localparam int PE_NUMBER = 4;
  localparam int PE_INDEX_WIDTH = 2;

  // Flag word on the up stream
  localparam int USER_WIDTH = 2;
  localparam int USER_OP_BIT = 0;
  localparam int USER_RSLT_BIT = 1;

  // Control unit state encoding
  localparam int ST_WIDTH = 3;
  localparam logic [ST_WIDTH-1:0] ST_START = 3'd0;
  localparam logic [ST_WIDTH-1:0] ST_STRL = 3'd1;
  localparam logic [ST_WIDTH-1:0] ST_STRU = 3'd2;
  localparam logic [ST_WIDTH-1:0] ST_MAC = 3'd3;
  localparam logic [ST_WIDTH-1:0] ST_END = 3'd4;
  localparam logic [ST_WIDTH-1:0] ST_ERR = 3'd5;

endpackage

`default_nettype wire

/* verilog/systolic_dot_top.sv */
`default_nettype none

module systolic_dot_top (
  input  wire                                                             clk,
  input  wire                                                             rst,
  input  wire [systolic_dot_pkg::PE_NUMBER-1:0]                           a_valid,
  input  wire [systolic_dot_pkg::PE_NUMBER-1:0][systolic_dot_pkg::DATA_WIDTH-1:0] a_data,
  input  wire [systolic_dot_pkg::PE_NUMBER-1:0]                           a_last,
  output wire [systolic_dot_pkg::PE_NUMBER-1:0]                           a_ready,
  input  wire                                                             b_valid,
  input  wire [systolic_dot_pkg::DATA_WIDTH-1:0]                          b_data,
  input  wire                                                             b_last,
  input  wire [systolic_dot_pkg::USER_WIDTH-1:0]                          b_user,
  output wire                                                             b_ready,
  output wire                                                             result_valid,
  output wire [systolic_dot_pkg::STREAM_WIDTH-1:0]                        result_data,
  output wire                                                             result_last,
  output wire [systolic_dot_pkg::USER_WIDTH-1:0]                          result_user,
  input  wire                                                             result_ready,
  output wire [systolic_dot_pkg::PE_NUMBER-1:0]                           err_unaligned,
  output wire [systolic_dot_pkg::PE_NUMBER-1:0]                           err_user_flag
);

  // Column links, index k is the up side of PE k
  wire [systolic_dot_pkg::PE_NUMBER:0] col_valid;
  wire [systolic_dot_pkg::PE_NUMBER:0] col_ready;
  wire [systolic_dot_pkg::PE_NUMBER:0] col_last;
  wire [systolic_dot_pkg::PE_NUMBER:0][systolic_dot_pkg::STREAM_WIDTH-1:0] col_data;
  wire [systolic_dot_pkg::PE_NUMBER:0][systolic_dot_pkg::USER_WIDTH-1:0] col_user;

  assign col_valid[0] = b_valid;
  assign col_data[0] = systolic_dot_pkg::STREAM_WIDTH'(b_data);
  assign col_last[0] = b_last;
  assign col_user[0] = b_user;
  assign b_ready = col_ready[0];

  assign result_valid = col_valid[systolic_dot_pkg::PE_NUMBER];
  assign result_data = col_data[systolic_dot_pkg::PE_NUMBER];
  assign result_last = col_last[systolic_dot_pkg::PE_NUMBER];
  assign result_user = col_user[systolic_dot_pkg::PE_NUMBER];
  assign col_ready[systolic_dot_pkg::PE_NUMBER] = result_ready;

  for (genvar k = 0; k < systolic_dot_pkg::PE_NUMBER; k++) begin : g_pe
    linear_processing_element #(.position(k)) u_pe (
      .clk(clk), .rst(rst),
      .up_valid(col_valid[k]), .up_data(col_data[k]), .up_last(col_last[k]),
      .up_user(col_user[k]), .up_ready(col_ready[k]),
      .left_valid(a_valid[k]), .left_data(a_data[k]), .left_last(a_last[k]),
      .left_ready(a_ready[k]),
      .down_valid(col_valid[k+1]), .down_data(col_data[k+1]), .down_last(col_last[k+1]),
      .down_user(col_user[k+1]), .down_ready(col_ready[k+1]),
      .err_unaligned(err_unaligned[k]), .err_user_flag(err_user_flag[k])
    );
  end

endmodule

`default_nettype wire
